//--- source/matrixMemPkg.sv
// Sizes, widths and bundled signal types for the matrix input loader
// Imported by every loader module and by the testbench
package matrixMemPkg;

    // Matrix geometry
    localparam int DataWidth = 12;  // One matrix element
    localparam int RowsM     = 7;   // Rows of A
    localparam int ColsN     = 9;   // Columns of B
    localparam int MaxK      = 8;   // Largest shared dimension

    // Derived widths, kept as fixed numbers
    localparam int KBits     = 4;   // Holds 1 to MaxK
    localparam int AAddrBits = 6;   // RowsM*MaxK = 56 words
    localparam int BAddrBits = 7;   // ColsN*MaxK = 72 words

    // Sideband that travels with the first word of a load
    typedef struct packed {
        logic [KBits-1:0] k;        // Shared dimension
        logic             newA;     // High means A is reloaded too
    } streamHeader;

    // One beat of the input word stream
    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic                 valid;
        streamHeader          header;
    } streamBeat;

    // Read addresses from the compute engine
    typedef struct packed {
        logic [AAddrBits-1:0] aAddr;
        logic [BAddrBits-1:0] bAddr;
    } readAddrPair;

    // Read data back to the compute engine
    typedef struct packed {
        logic signed [DataWidth-1:0] aData;
        logic signed [DataWidth-1:0] bData;
    } bankDataPair;

endpackage

//--- source/bankRam.sv
// Single-port synchronous RAM for one matrix bank
// Reads every cycle with one cycle of latency, writes when writeEnable is high
module bankRam
    import matrixMemPkg::*;
#(
    parameter int AddrBits = AAddrBits
) (
    input  logic                        clk,
    input  logic                        writeEnable,
    input  logic [AddrBits-1:0]         addr,
    input  logic [DataWidth-1:0]        writeData,
    output logic signed [DataWidth-1:0] readData
);

    localparam int Depth = 2 ** AddrBits;

    logic [DataWidth-1:0] mem [Depth];  // Contents only, no reset

    always_ff @(posedge clk) begin
        readData <= mem[addr];  // Old data on a write cycle
        if (writeEnable) begin
            mem[addr] <= writeData;
        end
    end

endmodule

//--- source/shapeRegister.sv
// Holds the shape of the current load
// Latches K from the stream header and precomputes the last write address of each
// bank, so the sequencer compares against held limits
module shapeRegister
    import matrixMemPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 captureHeader,
    input  streamHeader          header,
    output logic [KBits-1:0]     k,
    output logic [AAddrBits-1:0] lastAAddr,
    output logic [BAddrBits-1:0] lastBAddr
);

    logic [AAddrBits-1:0] aLimit;
    logic [BAddrBits-1:0] bLimit;

    // Final word index of each bank for the incoming K
    always_comb begin
        aLimit = AAddrBits'(RowsM * header.k - 1);  // RowsM*K words of A
        bLimit = BAddrBits'(ColsN * header.k - 1);  // ColsN*K words of B
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            k         <= '0;
            lastAAddr <= '0;
            lastBAddr <= '0;
        end else if (captureHeader) begin
            // Only the first word of a load carries a header worth keeping
            k         <= header.k;
            lastAAddr <= aLimit;
            lastBAddr <= bLimit;
        end
    end

endmodule

//--- source/loadSequencer.sv
// Load FSM for the input banks
// Steps write addresses through A then B as words arrive, raises matricesLoaded,
// then hands the bank addresses to the compute engine until computeFinished
module loadSequencer
    import matrixMemPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  streamBeat            stream,
    input  logic                 computeFinished,
    input  readAddrPair          readAddr,
    input  logic [AAddrBits-1:0] lastAAddr,
    input  logic [BAddrBits-1:0] lastBAddr,
    output logic                 captureHeader,
    output logic                 tReady,
    output logic                 matricesLoaded,
    output logic [AAddrBits-1:0] aAddr,
    output logic [BAddrBits-1:0] bAddr,
    output logic                 aWrite,
    output logic                 bWrite
);

    typedef enum logic [1:0] {
        awaitFirst,  // Idle, header comes with the next valid word
        storeA,
        storeB,
        loaded       // Banks belong to the compute engine
    } loadState;

    loadState state;

    // Write counters, both sit at zero while waiting for a load
    logic [AAddrBits-1:0] aCount;
    logic [BAddrBits-1:0] bCount;

    // Outputs decoded from state and the current beat
    always_comb begin
        captureHeader  = 1'b0;
        tReady         = 1'b1;
        matricesLoaded = 1'b0;
        aAddr          = aCount;  // Write side owns the banks by default
        bAddr          = bCount;
        aWrite         = 1'b0;
        bWrite         = 1'b0;

        case (state)
            awaitFirst: begin
                captureHeader = stream.valid;
                // First word lands at address 0 of the bank picked by newA
                aWrite = stream.valid && stream.header.newA;
                bWrite = stream.valid && !stream.header.newA;
            end

            storeA: begin
                aWrite = stream.valid;  // Stall cycles write nothing
            end

            storeB: begin
                bWrite = stream.valid;
            end

            loaded: begin
                tReady         = 1'b0;  // Stream is held off
                matricesLoaded = 1'b1;
                aAddr          = readAddr.aAddr;  // Engine reads both banks
                bAddr          = readAddr.bAddr;
            end

            default: begin
                tReady = 1'b0;
            end
        endcase
    end

    // State and counter updates
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= awaitFirst;
            aCount <= '0;
            bCount <= '0;
        end else begin
            case (state)
                awaitFirst: begin
                    if (stream.valid) begin
                        if (stream.header.newA) begin
                            state  <= storeA;
                            aCount <= aCount + 1'b1;
                        end else begin
                            state  <= storeB;  // B only, A keeps its contents
                            bCount <= bCount + 1'b1;
                        end
                    end
                end

                storeA: begin
                    if (stream.valid) begin
                        if (aCount == lastAAddr) begin
                            state <= storeB;  // bCount is still zero here
                        end else begin
                            aCount <= aCount + 1'b1;
                        end
                    end
                end

                storeB: begin
                    if (stream.valid) begin
                        if (bCount == lastBAddr) begin
                            state <= loaded;
                        end else begin
                            bCount <= bCount + 1'b1;
                        end
                    end
                end

                loaded: begin
                    if (computeFinished) begin
                        state  <= awaitFirst;
                        aCount <= '0;  // Ready for the next load at address 0
                        bCount <= '0;
                    end
                end

                default: begin
                    state <= awaitFirst;
                end
            endcase
        end
    end

endmodule

//--- source/inputMems.sv
// Matrix input loader top level
// Streams A and B into two banks, then serves random reads to the compute engine
// until computeFinished returns it to loading
module inputMems
    import matrixMemPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  streamBeat        stream,
    output logic             tReady,
    output logic             matricesLoaded,
    input  logic             computeFinished,
    output logic [KBits-1:0] k,
    input  readAddrPair      readAddr,
    output bankDataPair      readData
);

    logic                 captureHeader;
    logic [AAddrBits-1:0] lastAAddr;
    logic [BAddrBits-1:0] lastBAddr;
    logic [AAddrBits-1:0] aAddr;
    logic [BAddrBits-1:0] bAddr;
    logic                 aWrite;
    logic                 bWrite;

    loadSequencer sequencer (
        .clk            (clk),
        .reset          (reset),
        .stream         (stream),
        .computeFinished(computeFinished),
        .readAddr       (readAddr),
        .lastAAddr      (lastAAddr),
        .lastBAddr      (lastBAddr),
        .captureHeader  (captureHeader),
        .tReady         (tReady),
        .matricesLoaded (matricesLoaded),
        .aAddr          (aAddr),
        .bAddr          (bAddr),
        .aWrite         (aWrite),
        .bWrite         (bWrite)
    );

    shapeRegister shape (
        .clk          (clk),
        .reset        (reset),
        .captureHeader(captureHeader),
        .header       (stream.header),  // Sampled on the first word only
        .k            (k),
        .lastAAddr    (lastAAddr),
        .lastBAddr    (lastBAddr)
    );

    // Both banks take write data straight from the stream
    bankRam #(.AddrBits(AAddrBits)) bankA (
        .clk        (clk),
        .writeEnable(aWrite),
        .addr       (aAddr),
        .writeData  (stream.data),
        .readData   (readData.aData)
    );

    bankRam #(.AddrBits(BAddrBits)) bankB (
        .clk        (clk),
        .writeEnable(bWrite),
        .addr       (bAddr),
        .writeData  (stream.data),
        .readData   (readData.bData)
    );

endmodule

//--- tests/inputMemsTb.sv
// Testbench for the matrix input loader
// Streams the loads in tests/inputMemsInput.txt into the DUT, keeps a model of both banks
// and checks status timing, held-off stream and read-back of every load
module inputMemsTb
    import matrixMemPkg::*;
();

    localparam int ClockPeriod = 20;
    localparam int DriveDelay  = 2;     // Inputs change this long after the rising edge
    localparam int ResetCycles = 4;
    localparam int FileDepth   = 1024;
    localparam int ADepth      = RowsM * MaxK;
    localparam int BDepth      = ColsN * MaxK;

    logic             clk;
    logic             reset;
    streamBeat        stream;
    logic             tReady;
    logic             matricesLoaded;
    logic             computeFinished;
    logic [KBits-1:0] k;
    readAddrPair      readAddr;
    bankDataPair      readData;

    logic [15:0]          fileWords [FileDepth];  // Whole data file as hex tokens
    logic [DataWidth-1:0] modelA [ADepth];        // Expected bank contents
    logic [DataWidth-1:0] modelB [BDepth];

    int aSpan;  // Written A words over all loads
    int bSpan;
    int errors;
    int passedTests;
    int failedTests;
    int stallCount;
    int limitCycles;

    inputMems i_inputMems (
        .clk            (clk),
        .reset          (reset),
        .stream         (stream),
        .tReady         (tReady),
        .matricesLoaded (matricesLoaded),
        .computeFinished(computeFinished),
        .k              (k),
        .readAddr       (readAddr),
        .readData       (readData)
    );

    initial clk = 1'b0;
    always #(ClockPeriod / 2) clk = ~clk;

    // One clock plus the drive delay
    task automatic stepClock();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("mismatch %s: got %0h expected %0h", name, got, expected);
        errors++;
    endtask

    // Cycles a run may take with stall margin and read-back per load
    function automatic int countCycles();
        int idx;
        int words;
        int loads;
        int kVal;
        idx   = 0;
        words = 0;
        loads = 0;
        while (idx < FileDepth - 4 && fileWords[idx] != 0) begin
            kVal  = int'(fileWords[idx + 2]);
            words += (fileWords[idx + 1][0] ? RowsM * kVal : 0) + ColsN * kVal;
            idx   += 4 + (fileWords[idx + 1][0] ? RowsM * kVal : 0) + ColsN * kVal;
            loads++;
        end
        return words * 4 + loads * (4 * BDepth + 20) + ResetCycles + 50;
    endfunction

    // Random idle cycles before one accepted word
    task automatic sendWord(input logic [DataWidth-1:0] data, input bit first,
                            input streamHeader header, input int stallPct);
        while (int'($urandom_range(99)) < stallPct) begin
            stream.valid = 1'b0;
            stream.data  = DataWidth'($urandom);  // Junk that must not be written
            stepClock();
            stallCount++;
        end
        if (tReady !== 1'b1)
            reportMismatch("tReady", 32'(tReady), 32'h1);
        if (matricesLoaded !== 1'b0)
            reportMismatch("matricesLoaded", 32'(matricesLoaded), 32'h0);
        stream.valid = 1'b1;
        stream.data  = data;
        if (first) begin
            stream.header = header;
        end else begin
            stream.header.k    = KBits'($urandom);  // Only the first header counts
            stream.header.newA = 1'($urandom);
        end
        stepClock();
    endtask

    // Read every written address of both banks with data one cycle later
    task automatic readBack();
        int span;
        span = (aSpan > bSpan) ? aSpan : bSpan;
        for (int addr = 0; addr < span; addr++) begin
            readAddr.aAddr = (addr < aSpan) ? AAddrBits'(addr) : '0;
            readAddr.bAddr = (addr < bSpan) ? BAddrBits'(addr) : '0;
            stepClock();
            if (addr < aSpan && readData.aData !== modelA[addr])
                reportMismatch($sformatf("readData.aData[%0d]", addr),
                               32'($unsigned(readData.aData)), 32'(modelA[addr]));
            if (addr < bSpan && readData.bData !== modelB[addr])
                reportMismatch($sformatf("readData.bData[%0d]", addr),
                               32'($unsigned(readData.bData)), 32'(modelB[addr]));
        end
    endtask

    // Valid words while loaded must be ignored
    task automatic holdStream();
        for (int i = 0; i < 3; i++) begin
            stream.valid  = 1'b1;
            stream.data   = DataWidth'($urandom);
            stream.header = streamHeader'(5'($urandom));
            stepClock();
            if (tReady !== 1'b0)
                reportMismatch("tReady", 32'(tReady), 32'h0);
            if (matricesLoaded !== 1'b1)
                reportMismatch("matricesLoaded", 32'(matricesLoaded), 32'h1);
        end
        stream.valid = 1'b0;
    endtask

    // computeFinished pulse hands the banks back to the stream
    task automatic releaseBanks();
        stream.valid    = 1'b0;
        computeFinished = 1'b1;
        stepClock();
        computeFinished = 1'b0;
        if (tReady !== 1'b1)
            reportMismatch("tReady", 32'(tReady), 32'h1);
        if (matricesLoaded !== 1'b0)
            reportMismatch("matricesLoaded", 32'(matricesLoaded), 32'h0);
    endtask

    // Runs one load from the file and moves idx past it
    task automatic runLoad(inout int idx);
        int          testNum;
        int          loadK;
        int          stallPct;
        int          aWords;
        int          bWords;
        int          errorsBefore;
        streamHeader header;
        testNum      = int'(fileWords[idx]);
        loadK        = int'(fileWords[idx + 2]);
        stallPct     = int'(fileWords[idx + 3]);
        header.newA  = fileWords[idx + 1][0];
        header.k     = KBits'(loadK);
        errorsBefore = errors;
        stallCount   = 0;
        if (loadK < 1 || loadK > MaxK) begin
            $display("bad header in test %0d: k of %0d is out of range", testNum, loadK);
            errors++;
            failedTests++;
            idx = FileDepth;  // Nothing after a broken header can be trusted
            return;
        end
        idx    += 4;
        aWords = header.newA ? RowsM * loadK : 0;
        bWords = ColsN * loadK;
        for (int i = 0; i < aWords + bWords; i++) begin
            sendWord(fileWords[idx + i][DataWidth-1:0], i == 0, header, stallPct);
            if (i < aWords)
                modelA[i] = fileWords[idx + i][DataWidth-1:0];
            else
                modelB[i - aWords] = fileWords[idx + i][DataWidth-1:0];
            if (i == 0 && k !== header.k)
                reportMismatch("k", 32'(k), 32'(loadK));  // Latched after first word
        end
        idx += aWords + bWords;
        stream.valid = 1'b0;
        // Cycle right after the last B word
        if (matricesLoaded !== 1'b1)
            reportMismatch("matricesLoaded", 32'(matricesLoaded), 32'h1);
        if (tReady !== 1'b0)
            reportMismatch("tReady", 32'(tReady), 32'h0);
        if (k !== header.k)
            reportMismatch("k", 32'(k), 32'(loadK));
        aSpan = (aWords > aSpan) ? aWords : aSpan;
        bSpan = (bWords > bSpan) ? bWords : bSpan;
        readBack();
        holdStream();
        readBack();  // Contents unchanged by the held-off words
        releaseBanks();
        if (errors == errorsBefore) begin
            passedTests++;
            $display("test %0d: pass, %0d words, %0d stall cycles", testNum,
                     aWords + bWords, stallCount);
        end else begin
            failedTests++;
            $display("test %0d: FAIL, %0d errors", testNum, errors - errorsBefore);
        end
    endtask

    // Watchdog armed once the file length is known
    initial begin
        wait (limitCycles > 0);
        #(limitCycles * ClockPeriod);
        $display("timeout: the run did not finish within %0d cycles", limitCycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        int idx;
        int loadsRun;
        void'($urandom(32'he5c6));
        reset           = 1'b1;
        computeFinished = 1'b0;
        stream          = '0;
        readAddr        = '0;
        errors          = 0;
        passedTests     = 0;
        failedTests     = 0;
        aSpan           = 0;
        bSpan           = 0;
        loadsRun        = 0;
        for (int i = 0; i < FileDepth; i++) begin
            fileWords[i] = '0;  // Zero test number ends the walk
        end
        $readmemh("tests/inputMemsInput.txt", fileWords);
        limitCycles = countCycles();

        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;
        if (tReady !== 1'b1)
            reportMismatch("tReady", 32'(tReady), 32'h1);
        if (matricesLoaded !== 1'b0)
            reportMismatch("matricesLoaded", 32'(matricesLoaded), 32'h0);
        if (errors == 0) begin
            passedTests++;
            $display("test reset: pass");
        end else begin
            failedTests++;
            $display("test reset: FAIL, %0d errors", errors);
        end

        idx = 0;
        while (idx < FileDepth - 4 && fileWords[idx] != 0) begin
            runLoad(idx);
            loadsRun++;
        end
        if (loadsRun == 0) begin
            $display("no loads were found in the data file");
            errors++;
            failedTests++;
        end

        $display("summary: %0d passed, %0d failed, %0d mismatches", passedTests,
                 failedTests, errors);
        if (failedTests == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tests/inputMemsInput.txt
// Loads for the matrix input loader testbench, every field in hex
// Header: test number, newA, k, stall percent; then RowsM*k A words if newA, then ColsN*k B words
// A test number of 0 ends the file

1 1 2 0   // Full load, k 2
001 7ff 800 123 fed 0a5 5a0 3c3 c3c 111 222 333 444 fff
010 020 030 040 050 060 070 080 090 a00 b00 c00 d00 e00 f01 f02 f03 f04

2 0 3 0   // B only, k 3, A keeps test 1 contents
1a1 1a2 1a3 1a4 1a5 1a6 1a7 1a8 1a9 2b1 2b2 2b3 2b4 2b5 2b6 2b7
2b8 2b9 3c1 3c2 3c3 3c4 3c5 3c6 3c7 3c8 3c9

3 1 1 28  // Full load, k 1, 40 percent stalls
8a1 8a2 8a3 8a4 8a5 8a6 8a7
9b1 9b2 9b3 9b4 9b5 9b6 9b7 9b8 9b9

4 1 8 19  // Full load at k 8, 25 percent stalls
a00 a01 a02 a03 a04 a05 a06 a07 a08 a09 a0a a0b a0c a0d a0e a0f
a10 a11 a12 a13 a14 a15 a16 a17 a18 a19 a1a a1b a1c a1d a1e a1f
a20 a21 a22 a23 a24 a25 a26 a27 a28 a29 a2a a2b a2c a2d a2e a2f
a30 a31 a32 a33 a34 a35 a36 a37
b00 b01 b02 b03 b04 b05 b06 b07 b08 b09 b0a b0b b0c b0d b0e b0f
b10 b11 b12 b13 b14 b15 b16 b17 b18 b19 b1a b1b b1c b1d b1e b1f
b20 b21 b22 b23 b24 b25 b26 b27 b28 b29 b2a b2b b2c b2d b2e b2f
b30 b31 b32 b33 b34 b35 b36 b37 b38 b39 b3a b3b b3c b3d b3e b3f
b40 b41 b42 b43 b44 b45 b46 b47

5 0 5 32  // B only, k 5, 50 percent stalls
c00 c01 c02 c03 c04 c05 c06 c07 c08 c09 c0a c0b c0c c0d c0e c0f
c10 c11 c12 c13 c14 c15 c16 c17 c18 c19 c1a c1b c1c c1d c1e c1f
c20 c21 c22 c23 c24 c25 c26 c27 c28 c29 c2a c2b c2c

0 0 0 0   // End of loads

//--- list.f
source/matrixMemPkg.sv
source/bankRam.sv
source/shapeRegister.sv
source/loadSequencer.sv
source/inputMems.sv
tests/inputMemsTb.sv

//--- Makefile
# Verilator build and run for the matrix input loader testbench
# Any variable below can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= inputMemsTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILE_LIST LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
